/* rv_core.f */
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/reg_file.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/commit_unit.sv
hw/rv_core.sv
bench/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim

sim_output="$(./obj_dir/rv_core_sim)"
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

/* bench/rv_core_stimulus.txt */
// @00 program length, pc trace length | @10 program words | @50 expected pc of each cycle
// @a0 expected final x0..x31 | all values hex, eight per row
@00
0000003a 00000034
@10
fff00093 00500113 002081b3 40200233 800002b7 fff28313 0020c3b3 00516433
006274b3 0f014513 ff016593 7ff0f613 00b116b3 0022d733 4022d7b3 01c11813
0040d893 40125913 0020a9b3 0020ba33 00322a93 00323b13 00112bb3 fff13c13
00710013 00310463 00210463 001f8f93 00211463 00311463 001f8f93 00114463
0020c463 001f8f93 0020d463 00115463 001f8f93 0020e463 00116463 001f8f93
00117463 0020f463 001f8f93 00300c93 002d0d13 fffc8c93 fe0c9ce3 00c00def
001f8f93 001f8f93 00001e17 0e100e93 000e8f67 001f8f93 001f8f93 001f8f93
0080006f 001f8f93
@50
00000000 00000004 00000008 0000000c 00000010 00000014 00000018 0000001c
00000020 00000024 00000028 0000002c 00000030 00000034 00000038 0000003c
00000040 00000044 00000048 0000004c 00000050 00000054 00000058 0000005c
00000060 00000064 00000068 00000070 00000074 0000007c 00000080 00000088
0000008c 00000094 00000098 000000a0 000000a4 000000ac 000000b0 000000b4
000000b8 000000b0 000000b4 000000b8 000000b0 000000b4 000000b8 000000bc
000000c8 000000cc 000000d0 000000e0
@a0
00000000 ffffffff 00000005 00000004 fffffffb 80000000 7fffffff fffffffa
80000005 7ffffffb 000000f5 fffffff5 000007ff 00a00000 04000000 fc000000
50000000 0fffffff fffffffd 00000001 00000000 00000001 00000000 00000000
00000001 00000000 00000006 000000c0 000010c8 000000e1 000000d4 00000000

/* bench/rv_core_tb.sv */
// run from the project root so the stimulus path resolves; halt address is the word after the program
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_tb;

    // word offsets of the sections in the stimulus file
    localparam int STIM_WORDS   = 192;
    localparam int HDR_BASE     = 0;
    localparam int PROG_BASE    = 16;
    localparam int TRACE_BASE   = 80;
    localparam int REGS_BASE    = 160;
    localparam int MAX_PROG     = 64;
    localparam int MAX_TRACE    = 80;

    localparam int RESET_CYCLES = 3;
    localparam int RUN_TIMEOUT  = 200;
    localparam int DRIVE_DELAY  = 1;

    // JAL x0, 0 keeps the core parked past the program
    localparam logic [31:0] SELF_JUMP = 32'h0000_006f;

    logic                               clk;
    logic                               reset;
    logic [`RV_XLEN-1:0]                iaddr;
    logic [`RV_XLEN-1:0]                idata;
    logic [`RV_NREGS-1:0][`RV_XLEN-1:0] registers;

    logic [31:0] stim_mem [0:STIM_WORDS-1];
    logic [31:0] prog_len;
    logic [31:0] trace_len;

    int check_count;
    int mismatch_count;
    int failure_count;

    rv_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .iaddr_o     (iaddr),
        .idata_i     (idata),
        .registers_o (registers)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // word-addressed instruction memory
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] word_idx;
        word_idx = addr >> 2;
        if (word_idx < prog_len) begin
            return stim_mem[PROG_BASE + int'(word_idx)];
        end
        return SELF_JUMP;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic check_reset_state(input string phase);
        check_value($sformatf("%s pc", phase), `RV_RESET_PC, iaddr);
        for (int r = 0; r < `RV_NREGS; r++) begin
            check_value($sformatf("%s x%0d", phase, r), '0, registers[r]);
        end
    endtask

    initial begin
        int          cycle;
        int          trace_idx;
        logic [31:0] halt_addr;

        reset          = 1'b1;
        idata          = '0;
        check_count    = 0;
        mismatch_count = 0;
        failure_count  = 0;

        $readmemh("bench/rv_core_stimulus.txt", stim_mem);
        prog_len  = stim_mem[HDR_BASE];
        trace_len = stim_mem[HDR_BASE + 1];
        if (prog_len > MAX_PROG || trace_len > MAX_TRACE) begin
            failure_count++;
            $display("stimulus header gives lengths %0d and %0d, more than the file layout holds",
                     prog_len, trace_len);
            prog_len  = 0;
            trace_len = 0;
        end

        for (int c = 0; c < RESET_CYCLES; c++) begin
            next_cycle();
            check_reset_state("reset");
        end
        reset = 1'b0;
        idata = fetch_word(iaddr);
        check_reset_state("after reset");

        // one instruction per cycle until the pc parks at the halt address
        halt_addr = prog_len << 2;
        trace_idx = 0;
        cycle     = 0;
        while (iaddr != halt_addr && cycle < RUN_TIMEOUT) begin
            if (trace_idx < trace_len) begin
                check_value($sformatf("pc trace %0d", trace_idx),
                            stim_mem[TRACE_BASE + trace_idx], iaddr);
            end
            trace_idx++;
            next_cycle();
            idata = fetch_word(iaddr);
            cycle++;
        end

        if (iaddr != halt_addr) begin
            failure_count++;
            $display("timeout: pc did not reach halt address %h within %0d cycles",
                     halt_addr, RUN_TIMEOUT);
        end
        check_value("executed instruction count", trace_len, trace_idx);

        // x0 included, written by ADDI and JAL in the program
        for (int r = 0; r < `RV_NREGS; r++) begin
            check_value($sformatf("final x%0d", r), stim_mem[REGS_BASE + r], registers[r]);
        end

        $display("checks: %0d, mismatches: %0d, other failures: %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
// idata_i must settle in the same cycle as iaddr_o; no data memory, no stall, no exceptions
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module rv_core (
    input  wire                                 clk,
    input  wire                                 reset,
    output logic [`RV_XLEN-1:0]                 iaddr_o,
    input  wire [`RV_XLEN-1:0]                  idata_i,
    output logic [`RV_NREGS-1:0][`RV_XLEN-1:0]  registers_o
);
    import rv_core_pkg::*;

    decoded_t            dec;
    wb_t                 wb;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_result;
    logic                redirect;
    logic [`RV_XLEN-1:0] br_target;
    logic [`RV_XLEN-1:0] link;

    assign iaddr_o = pc;

    rv_decoder decoder_i (
        .instr_i (idata_i),
        .dec_o   (dec)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .reset      (reset),
        .rs1_idx_i  (dec.rs1),
        .rs2_idx_i  (dec.rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .regs_o     (registers_o)
    );

    // ALU and branch unit see the same decoded instruction in parallel
    int_alu int_alu_i (
        .dec_i      (dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .result_o   (alu_result)
    );

    branch_unit branch_unit_i (
        .dec_i      (dec),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc),
        .redirect_o (redirect),
        .target_o   (br_target),
        .link_o     (link)
    );

    commit_unit commit_unit_i (
        .clk          (clk),
        .reset        (reset),
        .dec_i        (dec),
        .alu_result_i (alu_result),
        .redirect_i   (redirect),
        .target_i     (br_target),
        .link_i       (link),
        .pc_o         (pc),
        .wb_o         (wb)
    );

endmodule

`default_nettype wire

/* hw/commit_unit.sv */
// one instruction retires per clk edge; write-back is not gated by reset, the register file is
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module commit_unit (
    input  wire                        clk,
    input  wire                        reset,
    input  wire rv_core_pkg::decoded_t dec_i,
    input  wire [`RV_XLEN-1:0]         alu_result_i,
    input  wire                        redirect_i,
    input  wire [`RV_XLEN-1:0]         target_i,
    input  wire [`RV_XLEN-1:0]         link_i,
    output logic [`RV_XLEN-1:0]        pc_o,
    output rv_core_pkg::wb_t           wb_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_next;
    logic                is_jump;

    assign is_jump = (dec_i.br_cond == BR_JAL) || (dec_i.br_cond == BR_JALR);

    // link is already pc + 4, the fall-through address
    assign pc_next = redirect_i ? target_i : link_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    assign wb_o.we    = dec_i.reg_write;
    assign wb_o.rd    = dec_i.rd;
    assign wb_o.value = is_jump ? link_i : alu_result_i;

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
// target is pc plus immediate for branches and JAL; misaligned targets are not trapped
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module branch_unit (
    input  wire rv_core_pkg::decoded_t dec_i,
    input  wire [`RV_XLEN-1:0]         rs1_data_i,
    input  wire [`RV_XLEN-1:0]         rs2_data_i,
    input  wire [`RV_XLEN-1:0]         pc_i,
    output logic                       redirect_o,
    output logic [`RV_XLEN-1:0]        target_o,
    output logic [`RV_XLEN-1:0]        link_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] jalr_sum;

    assign jalr_sum = rs1_data_i + dec_i.imm;

    always_comb begin
        target_o = pc_i + dec_i.imm;
        case (dec_i.br_cond)
            BR_EQ:   redirect_o = (rs1_data_i == rs2_data_i);
            BR_NE:   redirect_o = (rs1_data_i != rs2_data_i);
            BR_LT:   redirect_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_GE:   redirect_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            BR_LTU:  redirect_o = (rs1_data_i < rs2_data_i);
            BR_GEU:  redirect_o = (rs1_data_i >= rs2_data_i);
            BR_JAL:  redirect_o = 1'b1;
            BR_JALR: begin
                redirect_o = 1'b1;
                // bit 0 cleared per the ISA
                target_o   = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            end
            default: redirect_o = 1'b0;
        endcase
    end

    // return address for JAL and JALR
    assign link_o = pc_i + `RV_XLEN'(4);

endmodule

`default_nettype wire

/* hw/int_alu.sv */
// shifts use only the low RV_SHAMT_W bits of the second operand; unlisted ops return the operand
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module int_alu (
    input  wire rv_core_pkg::decoded_t dec_i,
    input  wire [`RV_XLEN-1:0]         rs1_data_i,
    input  wire [`RV_XLEN-1:0]         rs2_data_i,
    input  wire [`RV_XLEN-1:0]         pc_i,
    output logic [`RV_XLEN-1:0]        result_o
);
    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0]    op_b;
    logic [`RV_SHAMT_W-1:0] shamt;
    logic                   lt_s;
    logic                   lt_u;

    assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
    assign shamt = op_b[`RV_SHAMT_W-1:0];
    assign lt_s  = $signed(rs1_data_i) < $signed(op_b);
    assign lt_u  = rs1_data_i < op_b;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    result_o = rs1_data_i + op_b;
            ALU_SUB:    result_o = rs1_data_i - op_b;
            ALU_SLL:    result_o = rs1_data_i << shamt;
            ALU_SLT:    result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:    result_o = rs1_data_i ^ op_b;
            ALU_SRL:    result_o = rs1_data_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(rs1_data_i) >>> shamt);
            ALU_OR:     result_o = rs1_data_i | op_b;
            ALU_AND:    result_o = rs1_data_i & op_b;
            // LUI, immediate already shifted up by the decoder
            ALU_PASS_B: result_o = op_b;
            ALU_ADD_PC: result_o = pc_i + op_b;
            default:    result_o = op_b;
        endcase
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// reads are combinational and see the old value during a same-cycle write; x0 ignores writes
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module reg_file (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire [`RV_REG_AW-1:0]                 rs1_idx_i,
    input  wire [`RV_REG_AW-1:0]                 rs2_idx_i,
    input  wire rv_core_pkg::wb_t                wb_i,
    output logic [`RV_XLEN-1:0]                  rs1_data_o,
    output logic [`RV_XLEN-1:0]                  rs2_data_o,
    output logic [`RV_NREGS-1:0][`RV_XLEN-1:0]   regs_o
);

    logic [`RV_NREGS-1:0][`RV_XLEN-1:0] regs_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.value;
        end
    end

    assign rs1_data_o = regs_q[rs1_idx_i];
    assign rs2_data_o = regs_q[rs2_idx_i];

    // word i of the flat view is register xi
    assign regs_o = regs_q;

endmodule

`default_nettype wire

/* hw/rv_decoder.sv */
// unknown opcodes and unused branch funct3 values decode as no-ops; funct7 is only seen at bit 30
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_consts.svh"

module rv_decoder (
    input  wire [`RV_XLEN-1:0] instr_i,
    output rv_core_pkg::decoded_t dec_o
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e    opcode;
    funct3_e    funct3;
    logic       alt;
    instr_fmt_e fmt;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = funct3_e'(instr_i[14:12]);
    // funct7 bit that selects SUB and SRA
    assign alt    = instr_i[30];

    always_comb begin
        dec_o.rs1       = instr_i[19:15];
        dec_o.rs2       = instr_i[24:20];
        dec_o.rd        = instr_i[11:7];
        dec_o.reg_write = 1'b0;
        dec_o.use_imm   = 1'b0;
        dec_o.alu_op    = ALU_ADD;
        dec_o.br_cond   = BR_NONE;
        fmt             = FMT_NONE;

        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                dec_o.reg_write = 1'b1;
                dec_o.use_imm   = (opcode == OPC_OP_IMM);
                fmt             = (opcode == OPC_OP_IMM) ? FMT_I : FMT_R;
                case (funct3)
                    F3_ADD:  dec_o.alu_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  dec_o.alu_op = ALU_SLL;
                    F3_SLT:  dec_o.alu_op = ALU_SLT;
                    F3_SLTU: dec_o.alu_op = ALU_SLTU;
                    F3_XOR:  dec_o.alu_op = ALU_XOR;
                    F3_SRL:  dec_o.alu_op = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:   dec_o.alu_op = ALU_OR;
                    default: dec_o.alu_op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                dec_o.reg_write = 1'b1;
                dec_o.use_imm   = 1'b1;
                dec_o.alu_op    = ALU_PASS_B;
                fmt             = FMT_U;
            end
            OPC_AUIPC: begin
                dec_o.reg_write = 1'b1;
                dec_o.use_imm   = 1'b1;
                dec_o.alu_op    = ALU_ADD_PC;
                fmt             = FMT_U;
            end
            OPC_BRANCH: begin
                fmt = FMT_B;
                case (funct3)
                    F3_BEQ:  dec_o.br_cond = BR_EQ;
                    F3_BNE:  dec_o.br_cond = BR_NE;
                    F3_BLT:  dec_o.br_cond = BR_LT;
                    F3_BGE:  dec_o.br_cond = BR_GE;
                    F3_BLTU: dec_o.br_cond = BR_LTU;
                    F3_BGEU: dec_o.br_cond = BR_GEU;
                    default: dec_o.br_cond = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                dec_o.reg_write = 1'b1;
                dec_o.br_cond   = BR_JAL;
                fmt             = FMT_J;
            end
            OPC_JALR: begin
                dec_o.reg_write = 1'b1;
                dec_o.br_cond   = BR_JALR;
                fmt             = FMT_I;
            end
            default: begin
                dec_o.reg_write = 1'b0;
            end
        endcase

        // sign bit is always instr_i[31]
        case (fmt)
            FMT_I:   dec_o.imm = {{20{instr_i[31]}}, instr_i[31:20]};
            FMT_U:   dec_o.imm = {instr_i[31:12], 12'b0};
            FMT_B:   dec_o.imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                  instr_i[11:8], 1'b0};
            FMT_J:   dec_o.imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                  instr_i[30:21], 1'b0};
            default: dec_o.imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_core_pkg.sv */
// decoded fields assume RV_REG_AW-bit register indices and a full RV_XLEN immediate
`default_nettype none

`include "rv_core_consts.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B,
        ALU_ADD_PC
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JAL,
        BR_JALR
    } br_cond_e;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic                  reg_write;
        logic                  use_imm;
        alu_op_e               alu_op;
        br_cond_e              br_cond;
        logic [`RV_XLEN-1:0]   imm;
    } decoded_t;

    typedef struct packed {
        logic                  we;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
    } wb_t;

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
// only the opcodes and funct3 values of the integer subset are named; loads and stores are absent
`default_nettype none

package rv_isa_pkg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // funct3 of the ALU group
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // branch funct3 values share the encoding space of the ALU group
    localparam funct3_e F3_BEQ  = F3_ADD;
    localparam funct3_e F3_BNE  = F3_SLL;
    localparam funct3_e F3_BLT  = F3_XOR;
    localparam funct3_e F3_BGE  = F3_SRL;
    localparam funct3_e F3_BLTU = F3_OR;
    localparam funct3_e F3_BGEU = F3_AND;

    // immediate layout
    typedef enum logic [2:0] {
        FMT_NONE,
        FMT_R,
        FMT_I,
        FMT_U,
        FMT_B,
        FMT_J
    } instr_fmt_e;

endpackage

`default_nettype wire

/* include/rv_core_consts.svh */
// all widths assume RV32I; changing RV_XLEN alone does not give a 64-bit core
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// register index width
`define RV_REG_AW 5

// shift amount width, low bits of the second operand
`define RV_SHAMT_W 5

// first fetch address
`define RV_RESET_PC 32'h0000_0000

`endif
